// File: all.f
logic/ooo_pkg.sv
logic/issue_control.sv
logic/reg_status.sv
logic/reorder_buffer.sv
logic/ooo_dispatch.sv
verif/dispatch_checker.sv
verif/dispatch_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP = dispatch_tb
FILELIST = all.f
OBJDIR = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf $(OBJDIR)

// File: verif/dispatch_tb.sv
`timescale 1ns/100ps

module dispatch_tb;
	import ooo_pkg::*;

	localparam int NUM_INSTR = 400;
	localparam int PERIOD = 100;
	localparam int FULL_START = 200; // ROB-full phase begins here
	localparam int FULL_CYCLES = 40;

	logic clk = 1'b0;
	logic arst_n;
	word_t instr;
	logic instr_is_new;
	word_t curr_pc;
	logic predict_bit;
	cdb_t cdb;
	station_busy_t station_busy;
	logic ldst_full;
	logic stall;
	logic pcmux_sel;
	word_t br_pc;
	alu_issue_t alu_issue;
	ldst_issue_t ldst_issue;
	commit_t commit;
	logic [ROB_DEPTH-1:0] pending;
	int errors;
	int checks;

	logic [15:0] lfsr;
	word_t pc;
	int consumed;
	int idle_cycles;
	logic hold;
	logic full_phase;

	ooo_dispatch dut0 (.*);
	dispatch_checker chk0 (.*);

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[14:0], fb};
		end
		return r;
	endfunction

	function automatic word_t make_instr(input logic alu_only);
		opcode_t ops [8];
		word_t w;
		ops = '{op_add, op_and, op_not, op_shf, op_ldr, op_str, op_br, op_lea};
		w = rand_bits(16);
		if (alu_only)
			w[15:12] = ops[2'(rand_bits(2))];
		else
			w[15:12] = ops[3'(rand_bits(3))];
		if (w[15:12] == op_not)
			w[5:0] = 6'h3f; // NOT always carries ones here
		return w;
	endfunction

	// Only tags still waiting on a result
	function automatic cdb_t pick_broadcast();
		cdb_t c;
		rob_tag_t t;
		c = '0;
		t = rob_tag_t'(rand_bits(TAG_W));
		if (pending != '0 && rand_bits(2) != 16'd0)
		begin
			while (!pending[t])
				t = t + 1'b1;
			c.valid = 1'b1;
			c.tag = t;
			c.data = rand_bits(16);
		end
		return c;
	endfunction

	initial
	begin
		forever #(PERIOD / 2) clk = ~clk;
	end

	// Watchdog
	initial
	begin
		#((NUM_INSTR * 60 + 2) * PERIOD);
		$display("Timeout with %0d of %0d instructions consumed", consumed, NUM_INSTR);
		$display("Checks %0d, errors %0d", checks, errors);
		$display("Result: FAILED");
		$finish;
	end

	initial
	begin
		lfsr = 16'd18452;
		arst_n = 1'b0;
		instr = '0;
		instr_is_new = 1'b0;
		curr_pc = '0;
		predict_bit = 1'b0;
		cdb = '0;
		station_busy = '0;
		ldst_full = 1'b0;
		pc = 16'h3000;
		consumed = 0;
		idle_cycles = 0;
		repeat (2) @(posedge clk);
		#10 arst_n = 1'b1;

		while (consumed < NUM_INSTR)
		begin
			@(negedge clk);
			hold = stall; // Fetch keeps the word while stalled
			if (pcmux_sel)
				pc = br_pc;
			else if (instr_is_new && !stall)
				pc = curr_pc + 16'd2;
			if (instr_is_new && !stall)
				consumed++;
			@(posedge clk);
			#10;
			full_phase = (consumed >= FULL_START) && (idle_cycles < FULL_CYCLES);
			if (full_phase)
				idle_cycles++;
			if (!hold)
			begin
				instr_is_new = full_phase || (rand_bits(3) != 16'd0);
				instr = make_instr(full_phase);
				predict_bit = 1'(rand_bits(1));
				curr_pc = pc;
			end
			if (consumed < 100 || full_phase)
			begin
				station_busy = '0;
				ldst_full = 1'b0;
			end
			else
			begin
				station_busy = station_busy_t'(rand_bits(3));
				ldst_full = (rand_bits(2) == 16'd0);
			end
			cdb = full_phase ? '0 : pick_broadcast();
		end

		// Drain what is still in flight
		@(posedge clk);
		#10 instr_is_new = 1'b0;
		while (pending != '0)
		begin
			@(posedge clk);
			#10 cdb = pick_broadcast();
		end
		repeat (ROB_DEPTH + 4) @(posedge clk);

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// File: verif/dispatch_checker.sv
`timescale 1ns/100ps

module dispatch_checker
(
	input logic clk,
	input logic arst_n,
	input ooo_pkg::word_t instr,
	input logic instr_is_new,
	input ooo_pkg::word_t curr_pc,
	input logic predict_bit,
	input ooo_pkg::cdb_t cdb,
	input ooo_pkg::station_busy_t station_busy,
	input logic ldst_full,
	input logic stall,
	input logic pcmux_sel,
	input ooo_pkg::word_t br_pc,
	input ooo_pkg::alu_issue_t alu_issue,
	input ooo_pkg::ldst_issue_t ldst_issue,
	input ooo_pkg::commit_t commit,
	output logic [ooo_pkg::ROB_DEPTH-1:0] pending,
	output int errors,
	output int checks
);
	import ooo_pkg::*;

	typedef struct packed {logic ready; word_t value; rob_tag_t tag;} opnd_t;

	// Shadow register file and status table
	word_t reg_val [8];
	logic [7:0] reg_busy;
	rob_tag_t reg_tag [8];

	// Shadow ROB
	logic [ROB_DEPTH-1:0] live;
	logic [ROB_DEPTH-1:0] ready;
	logic [ROB_DEPTH-1:0] rob_wr;
	word_t rob_val [ROB_DEPTH];
	reg_idx_t rob_dest [ROB_DEPTH];
	opcode_t rob_op [ROB_DEPTH];
	rob_tag_t head, tail;
	int count;
	logic bubble;

	int err_count = 0;
	int check_count = 0;

	assign pending = live & ~ready;
	assign errors = err_count;
	assign checks = check_count;

	// Register, same-cycle CDB, finished ROB entry, else wait
	function automatic opnd_t expect_operand(input reg_idx_t r);
		opnd_t o;
		o = '0;
		o.tag = reg_tag[r];
		if (!reg_busy[r])
		begin
			o.ready = 1'b1;
			o.value = reg_val[r];
		end
		else if (cdb.valid && cdb.tag == reg_tag[r])
		begin
			o.ready = 1'b1;
			o.value = cdb.data;
		end
		else if (ready[reg_tag[r]])
		begin
			o.ready = 1'b1;
			o.value = rob_val[reg_tag[r]];
		end
		return o;
	endfunction

	function automatic word_t expect_offset(input word_t w);
		return {{9{w[5]}}, w[5:0], 1'b0};
	endfunction

	function automatic word_t expect_branch(input word_t pc, input word_t w);
		return pc + {{6{w[8]}}, w[8:0], 1'b0};
	endfunction

	task automatic compare(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		check_count++;
		if (actual !== expected)
		begin
			err_count++;
			$display("Fail %s: expected %h, actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic compare_operand(input string name, input opnd_t e, input logic rdy,
		input word_t v, input rob_tag_t q);
		compare({name, "_ready"}, 16'(e.ready), 16'(rdy));
		if (e.ready)
			compare({name, "_value"}, e.value, v);
		else
			compare({name, "_tag"}, 16'(e.tag), 16'(q));
	endtask

	always @(negedge clk)
	begin
		opcode_t op;
		logic is_alu, is_ldst, is_rob_only, writes, cond, go, taken, retire;
		logic [1:0] stn;
		opnd_t j, k, s;
		if (!arst_n)
		begin
			for (int i = 0; i < 8; i++)
			begin
				reg_val[i] = '0;
				reg_tag[i] = '0;
				rob_val[i] = '0;
				rob_dest[i] = '0;
				rob_op[i] = op_br;
			end
			reg_busy = '0;
			live = '0;
			ready = '0;
			rob_wr = '0;
			head = '0;
			tail = '0;
			count = 0;
			bubble = 1'b0;
			compare("reset_stall", 16'd0, 16'(stall));
			compare("reset_pcmux_sel", 16'd0, 16'(pcmux_sel));
			compare("reset_alu_valid", 16'd0, 16'(alu_issue.valid));
			compare("reset_ldst_valid", 16'd0, 16'(ldst_issue.valid));
			compare("reset_commit_valid", 16'd0, 16'(commit.valid));
		end
		else
		begin
			op = opcode_t'(instr[15:12]);
			is_alu = op inside {op_add, op_and, op_not, op_shf};
			is_ldst = op inside {op_ldr, op_str};
			is_rob_only = op inside {op_br, op_lea};
			writes = is_alu || op == op_ldr || op == op_lea;
			cond = (count == ROB_DEPTH) || (is_alu && (&station_busy)) ||
				(is_ldst && ldst_full);
			go = instr_is_new && !bubble && !cond;
			taken = go && op == op_br && predict_bit;
			retire = (count != 0) && ready[head];
			stn = !station_busy[0] ? 2'd0 : (!station_busy[1] ? 2'd1 : 2'd2);
			j = expect_operand(instr[8:6]);
			s = expect_operand(instr[11:9]); // Store source
			if (instr[5] || op == op_shf)
				k = '{ready: 1'b1, value: {{11{instr[4]}}, instr[4:0]}, tag: '0};
			else
				k = expect_operand(instr[2:0]);

			compare("stall", 16'(instr_is_new && !bubble && cond), 16'(stall));
			compare("pcmux_sel", 16'(taken), 16'(pcmux_sel));
			if (go && is_rob_only)
				compare("br_pc", expect_branch(curr_pc, instr), br_pc);
			compare("alu_valid", 16'(go && is_alu), 16'(alu_issue.valid));
			if (go && is_alu)
			begin
				compare("alu_op", 16'(op), 16'(alu_issue.op));
				compare("alu_station", 16'(stn), 16'(alu_issue.station));
				compare("alu_dest", 16'(tail), 16'(alu_issue.dest));
				compare_operand("alu_j", j, alu_issue.j_ready, alu_issue.vj, alu_issue.qj);
				compare_operand("alu_k", k, alu_issue.k_ready, alu_issue.vk, alu_issue.qk);
			end
			compare("ldst_valid", 16'(go && is_ldst), 16'(ldst_issue.valid));
			if (go && is_ldst)
			begin
				compare("ldst_store", 16'(op == op_str), 16'(ldst_issue.is_store));
				compare("ldst_offset", expect_offset(instr), ldst_issue.offset);
				compare("ldst_dest", 16'(tail), 16'(ldst_issue.dest));
				compare_operand("ldst_base", j, ldst_issue.base_ready, ldst_issue.vbase,
					ldst_issue.qbase);
				if (op == op_str)
					compare_operand("ldst_src", s, ldst_issue.src_ready, ldst_issue.vsrc,
						ldst_issue.qsrc);
			end
			compare("commit_valid", 16'(retire), 16'(commit.valid));
			if (retire)
			begin
				compare("commit_tag", 16'(head), 16'(commit.tag));
				compare("commit_op", 16'(rob_op[head]), 16'(commit.op));
				compare("commit_value", rob_val[head], commit.value);
				compare("commit_writes", 16'(rob_wr[head]), 16'(commit.writes_reg));
				if (rob_wr[head])
					compare("commit_dest", 16'(rob_dest[head]), 16'(commit.dest));
			end

			// State after the coming edge
			if (retire)
			begin
				if (rob_wr[head])
				begin
					reg_val[rob_dest[head]] = rob_val[head];
					if (reg_tag[rob_dest[head]] == head)
						reg_busy[rob_dest[head]] = 1'b0;
				end
				live[head] = 1'b0;
				head = head + 1'b1;
				count--;
			end
			if (cdb.valid)
			begin
				ready[cdb.tag] = 1'b1;
				rob_val[cdb.tag] = cdb.data;
			end
			if (go && (is_alu || is_ldst || is_rob_only))
			begin
				live[tail] = 1'b1;
				ready[tail] = is_rob_only;
				rob_wr[tail] = writes;
				rob_dest[tail] = instr[11:9];
				rob_op[tail] = op;
				rob_val[tail] = '0;
				if (op == op_br)
					rob_val[tail] = predict_bit ? curr_pc : expect_branch(curr_pc, instr);
				else if (op == op_lea)
					rob_val[tail] = expect_branch(curr_pc, instr);
				if (writes) // Rename wins over a commit clear
				begin
					reg_busy[instr[11:9]] = 1'b1;
					reg_tag[instr[11:9]] = tail;
				end
				tail = tail + 1'b1;
				count++;
			end
			bubble = taken;
		end
	end

endmodule

// File: logic/ooo_dispatch.sv
`timescale 1ns/100ps

module ooo_dispatch
(
	input logic clk,
	input logic arst_n,
	input ooo_pkg::word_t instr,
	input logic instr_is_new,
	input ooo_pkg::word_t curr_pc,
	input logic predict_bit,
	input ooo_pkg::cdb_t cdb,
	input ooo_pkg::station_busy_t station_busy,
	input logic ldst_full,
	output logic stall,
	output logic pcmux_sel,
	output ooo_pkg::word_t br_pc,
	output ooo_pkg::alu_issue_t alu_issue,
	output ooo_pkg::ldst_issue_t ldst_issue,
	output ooo_pkg::commit_t commit
);
	import ooo_pkg::*;

	reg_idx_t src1_idx, src2_idx, dest_idx, rename_reg;
	reg_read_t src1_read, src2_read, dest_read;
	rob_tag_t src1_look, src2_look, alloc_tag;
	rob_lookup_t src1_rob, src2_rob;
	rob_alloc_t rob_alloc;
	logic rob_full, rename_en;

	issue_control issue0 (.*);

	reg_status regs0
	(
		.clk, .arst_n, .src1_idx, .src2_idx, .dest_idx,
		.rename_en, .rename_reg, .rename_tag(alloc_tag), .commit,
		.src1_read, .src2_read, .dest_read
	);

	reorder_buffer rob0
	(
		.clk, .arst_n, .rob_alloc, .cdb,
		.look1(src1_look), .look2(src2_look),
		.alloc_tag, .rob_full, .res1(src1_rob), .res2(src2_rob), .commit
	);

endmodule

// File: logic/reorder_buffer.sv
`timescale 1ns/100ps

module reorder_buffer
(
	input logic clk,
	input logic arst_n,
	input ooo_pkg::rob_alloc_t rob_alloc,
	input ooo_pkg::cdb_t cdb,
	input ooo_pkg::rob_tag_t look1,
	input ooo_pkg::rob_tag_t look2,
	output ooo_pkg::rob_tag_t alloc_tag,
	output logic rob_full,
	output ooo_pkg::rob_lookup_t res1,
	output ooo_pkg::rob_lookup_t res2,
	output ooo_pkg::commit_t commit
);
	import ooo_pkg::*;

	typedef struct packed
	{
		opcode_t op;
		reg_idx_t dest;
		logic writes_reg;
		logic ready;
		word_t value;
	} rob_entry_t;

	rob_entry_t ent [ROB_DEPTH];
	rob_tag_t head, tail;
	logic [TAG_W:0] count; // One extra bit to tell full from empty
	logic do_commit;

	assign alloc_tag = tail;
	assign rob_full = (count == (TAG_W+1)'(ROB_DEPTH));

	assign res1 = '{ready: ent[look1].ready, value: ent[look1].value};
	assign res2 = '{ready: ent[look2].ready, value: ent[look2].value};

	// Head retires once its result is in
	assign do_commit = (count != '0) && ent[head].ready;

	always_comb
	begin
		commit = '0;
		commit.valid = do_commit;
		commit.op = ent[head].op;
		commit.dest = ent[head].dest;
		commit.writes_reg = ent[head].writes_reg;
		commit.tag = head;
		commit.value = ent[head].value;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end
		else
		begin
			if (rob_alloc.valid)
				tail <= tail + 1'b1;
			if (do_commit)
				head <= head + 1'b1;
			count <= count + (TAG_W+1)'(rob_alloc.valid) - (TAG_W+1)'(do_commit);
		end
	end

	// Entry payload and CDB capture
	always_ff @(posedge clk)
	begin
		if (cdb.valid)
		begin
			ent[cdb.tag].ready <= 1'b1;
			ent[cdb.tag].value <= cdb.data;
		end
		if (rob_alloc.valid)
		begin
			ent[tail].op <= rob_alloc.op;
			ent[tail].dest <= rob_alloc.dest;
			ent[tail].writes_reg <= rob_alloc.writes_reg; // Low for STR and BR
			ent[tail].ready <= rob_alloc.value_ready;
			ent[tail].value <= rob_alloc.value;
		end
	end

endmodule

// File: logic/reg_status.sv
`timescale 1ns/100ps

module reg_status
(
	input logic clk,
	input logic arst_n,
	input ooo_pkg::reg_idx_t src1_idx,
	input ooo_pkg::reg_idx_t src2_idx,
	input ooo_pkg::reg_idx_t dest_idx,
	input logic rename_en,
	input ooo_pkg::reg_idx_t rename_reg,
	input ooo_pkg::rob_tag_t rename_tag,
	input ooo_pkg::commit_t commit,
	output ooo_pkg::reg_read_t src1_read,
	output ooo_pkg::reg_read_t src2_read,
	output ooo_pkg::reg_read_t dest_read
);
	import ooo_pkg::*;

	word_t data [8];
	logic [7:0] busy;
	rob_tag_t tag [8];

	assign src1_read = '{busy: busy[src1_idx], tag: tag[src1_idx], data: data[src1_idx]};
	assign src2_read = '{busy: busy[src2_idx], tag: tag[src2_idx], data: data[src2_idx]};
	assign dest_read = '{busy: busy[dest_idx], tag: tag[dest_idx], data: data[dest_idx]};

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			busy <= '0;
			for (int i = 0; i < 8; i++)
			begin
				data[i] <= '0;
				tag[i] <= '0;
			end
		end
		else
		begin
			if (commit.valid && commit.writes_reg)
			begin
				data[commit.dest] <= commit.value;
				// A younger rename keeps the register busy
				if (tag[commit.dest] == commit.tag)
					busy[commit.dest] <= 1'b0;
			end
			if (rename_en) // Overrides the commit clear
			begin
				busy[rename_reg] <= 1'b1;
				tag[rename_reg] <= rename_tag;
			end
		end
	end

endmodule

// File: logic/issue_control.sv
`timescale 1ns/100ps

module issue_control
(
	input logic clk,
	input logic arst_n,
	input ooo_pkg::word_t instr,
	input logic instr_is_new,
	input ooo_pkg::word_t curr_pc,
	input logic predict_bit,
	input ooo_pkg::cdb_t cdb,
	input ooo_pkg::station_busy_t station_busy,
	input logic ldst_full,
	input logic rob_full,
	input ooo_pkg::rob_tag_t alloc_tag,
	input ooo_pkg::reg_read_t src1_read,
	input ooo_pkg::reg_read_t src2_read,
	input ooo_pkg::reg_read_t dest_read,
	input ooo_pkg::rob_lookup_t src1_rob,
	input ooo_pkg::rob_lookup_t src2_rob,
	output logic stall,
	output logic pcmux_sel,
	output ooo_pkg::word_t br_pc,
	output ooo_pkg::reg_idx_t src1_idx,
	output ooo_pkg::reg_idx_t src2_idx,
	output ooo_pkg::reg_idx_t dest_idx,
	output ooo_pkg::rob_tag_t src1_look,
	output ooo_pkg::rob_tag_t src2_look,
	output ooo_pkg::alu_issue_t alu_issue,
	output ooo_pkg::ldst_issue_t ldst_issue,
	output ooo_pkg::rob_alloc_t rob_alloc,
	output logic rename_en,
	output ooo_pkg::reg_idx_t rename_reg
);
	import ooo_pkg::*;

	typedef struct packed {logic ready; word_t value; rob_tag_t tag;} operand_t;

	// Register, then same-cycle CDB, then finished ROB entry, else wait on tag
	function automatic operand_t resolve(input reg_read_t rd, input rob_lookup_t lk,
		input cdb_t bus);
		operand_t o;
		o = '0;
		if (!rd.busy)
		begin
			o.ready = 1'b1;
			o.value = rd.data;
		end
		else if (bus.valid && bus.tag == rd.tag)
		begin
			o.ready = 1'b1;
			o.value = bus.data;
		end
		else if (lk.ready)
		begin
			o.ready = 1'b1;
			o.value = lk.value;
		end
		else
			o.tag = rd.tag;
		return o;
	endfunction

	opcode_t opcode;
	word_t sext5;
	word_t off6;
	word_t off9;
	logic is_alu, is_ldst, is_store, is_br, is_lea, writes_reg;
	logic use_imm;
	logic stall_cond, go, bubble;
	logic [1:0] station;
	operand_t opnd_j, opnd_k, opnd_src;

	assign opcode = opcode_t'(instr[15:12]);
	assign src1_idx = instr[8:6]; // SR1 or base register
	assign src2_idx = instr[2:0];
	assign dest_idx = instr[11:9]; // DR, or the source of a store

	assign sext5 = {{11{instr[4]}}, instr[4:0]};
	assign off6 = {{9{instr[5]}}, instr[5:0], 1'b0};
	assign off9 = {{6{instr[8]}}, instr[8:0], 1'b0};
	assign br_pc = curr_pc + off9;

	assign is_alu = (opcode == op_add) || (opcode == op_and) ||
		(opcode == op_not) || (opcode == op_shf);
	assign is_store = (opcode == op_str);
	assign is_ldst = (opcode == op_ldr) || is_store;
	assign is_br = (opcode == op_br);
	assign is_lea = (opcode == op_lea);
	assign writes_reg = is_alu || (opcode == op_ldr) || is_lea;
	assign use_imm = instr[5] || (opcode == op_shf); // NOT also lands here

	// Store source is looked up through the second ROB port
	assign src1_look = src1_read.tag;
	assign src2_look = is_store ? dest_read.tag : src2_read.tag;

	assign opnd_j = resolve(src1_read, src1_rob, cdb);
	assign opnd_src = resolve(dest_read, src2_rob, cdb);
	assign opnd_k = use_imm ? operand_t'{ready: 1'b1, value: sext5, tag: '0}
		: resolve(src2_read, src2_rob, cdb);

	assign stall_cond = rob_full || (is_alu && (&station_busy)) || (is_ldst && ldst_full);
	assign stall = instr_is_new && !bubble && stall_cond;
	assign go = instr_is_new && !bubble && !stall_cond;

	assign pcmux_sel = go && is_br && predict_bit;
	assign rename_en = go && writes_reg;
	assign rename_reg = dest_idx;

	always_comb
	begin
		if (!station_busy[0])
			station = 2'd0;
		else if (!station_busy[1])
			station = 2'd1;
		else
			station = 2'd2;
	end

	// Word after a predicted-taken branch is on the wrong path
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			bubble <= 1'b0;
		else
			bubble <= pcmux_sel;
	end

	always_comb
	begin
		alu_issue = '0;
		ldst_issue = '0;
		rob_alloc = '0;
		if (go && is_alu)
		begin
			alu_issue.valid = 1'b1;
			alu_issue.op = opcode;
			alu_issue.station = station;
			alu_issue.vj = opnd_j.value;
			alu_issue.qj = opnd_j.tag;
			alu_issue.j_ready = opnd_j.ready;
			alu_issue.vk = opnd_k.value;
			alu_issue.qk = opnd_k.tag;
			alu_issue.k_ready = opnd_k.ready;
			alu_issue.dest = alloc_tag;
		end
		if (go && is_ldst)
		begin
			ldst_issue.valid = 1'b1;
			ldst_issue.is_store = is_store;
			ldst_issue.offset = off6;
			ldst_issue.vbase = opnd_j.value;
			ldst_issue.qbase = opnd_j.tag;
			ldst_issue.base_ready = opnd_j.ready;
			ldst_issue.vsrc = is_store ? opnd_src.value : '0;
			ldst_issue.qsrc = is_store ? opnd_src.tag : '0;
			ldst_issue.src_ready = is_store ? opnd_src.ready : 1'b1; // Loads have no source
			ldst_issue.dest = alloc_tag;
		end
		if (go && (is_alu || is_ldst || is_br || is_lea))
		begin
			rob_alloc.valid = 1'b1;
			rob_alloc.op = opcode;
			rob_alloc.dest = dest_idx;
			rob_alloc.writes_reg = writes_reg;
			rob_alloc.value_ready = is_br || is_lea;
			// Taken branch keeps the fall-through PC for recovery
			if (is_br)
				rob_alloc.value = predict_bit ? curr_pc : br_pc;
			else if (is_lea)
				rob_alloc.value = br_pc;
		end
	end

endmodule

// File: logic/ooo_pkg.sv
package ooo_pkg;

	localparam int TAG_W = 3;
	localparam int ROB_DEPTH = 1 << TAG_W;

	typedef logic [15:0] word_t;
	typedef logic [2:0] reg_idx_t;
	typedef logic [TAG_W-1:0] rob_tag_t;
	typedef logic [2:0] station_busy_t; // Bit n is ALU station n

	// LC-3b opcode field
	typedef enum logic [3:0]
	{
		op_br   = 4'h0,
		op_add  = 4'h1,
		op_ldb  = 4'h2,
		op_stb  = 4'h3,
		op_jsr  = 4'h4,
		op_and  = 4'h5,
		op_ldr  = 4'h6,
		op_str  = 4'h7,
		op_rti  = 4'h8,
		op_not  = 4'h9,
		op_ldi  = 4'ha,
		op_sti  = 4'hb,
		op_jmp  = 4'hc,
		op_shf  = 4'hd,
		op_lea  = 4'he,
		op_trap = 4'hf
	} opcode_t;

	typedef struct packed {logic valid; rob_tag_t tag; word_t data;} cdb_t;

	typedef struct packed {logic busy; rob_tag_t tag; word_t data;} reg_read_t;

	typedef struct packed {logic ready; word_t value;} rob_lookup_t;

	typedef struct packed
	{
		logic valid;
		opcode_t op;
		logic [1:0] station;
		word_t vj;
		word_t vk;
		rob_tag_t qj;
		rob_tag_t qk;
		logic j_ready;
		logic k_ready;
		rob_tag_t dest;
	} alu_issue_t;

	typedef struct packed
	{
		logic valid;
		logic is_store;
		word_t offset; // Already shifted to a byte offset
		word_t vbase;
		rob_tag_t qbase;
		logic base_ready;
		word_t vsrc;
		rob_tag_t qsrc;
		logic src_ready;
		rob_tag_t dest;
	} ldst_issue_t;

	typedef struct packed
	{
		logic valid;
		opcode_t op;
		reg_idx_t dest;
		logic writes_reg;
		word_t value;
		logic value_ready; // BR and LEA finish at dispatch
	} rob_alloc_t;

	typedef struct packed
	{
		logic valid;
		opcode_t op;
		reg_idx_t dest;
		logic writes_reg;
		rob_tag_t tag;
		word_t value;
	} commit_t;

endpackage
